//--- Makefile
RTL = stream_pkg.sv ip_hdr_pkg.sv pkt_fifo.sv hdr_decode.sv route_exec.sv \
      out_rewrite.sv router_opl_top.sv

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module tb_router_opl -f files.f -o sim
	./obj_dir/sim | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --top-module router_opl_top $(RTL)

clean:
	rm -rf obj_dir sim.log

//--- files.f
stream_pkg.sv
ip_hdr_pkg.sv
pkt_fifo.sv
hdr_decode.sv
route_exec.sv
out_rewrite.sv
router_opl_top.sv
router_opl_chk.sv
tb_router_opl.sv

//--- hdr_decode.sv
//********************************************************************
// Beat position tracking (header, second, rest) at the FIFO head
// Pop and fire strobes, source port slice out of tuser
//********************************************************************

`timescale 1ns/1ps

module hdr_decode (
  input  logic                              AXI_ACLK,
  input  logic                              AXI_RESETN,
  input  logic                              head_valid,
  input  logic                              head_last,
  input  logic [stream_pkg::TUSER_W-1:0]    head_tuser,
  input  logic                              out_ready,
  output logic                              pop,
  output logic                              beat_fire,
  output logic                              hdr_beat,
  output logic                              second_fire,
  output logic [stream_pkg::PORT_W-1:0]     src_port
);

  logic [ip_hdr_pkg::POS_W-1:0] pos;  // Where the head beat sits

  // Head beat leaves this cycle
  assign beat_fire = head_valid & out_ready;
  assign pop       = beat_fire;       // FIFO advances on every transfer

  // First beat visible at the head, used for rewrite and sum start
  assign hdr_beat    = head_valid & (pos == ip_hdr_pkg::POS_HDR);
  assign second_fire = beat_fire & (pos == ip_hdr_pkg::POS_SECOND);

  assign src_port = head_tuser[stream_pkg::SRC_PORT_POS +: stream_pkg::PORT_W];

  // Header -> second -> rest, any tlast goes back to header
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      pos <= ip_hdr_pkg::POS_HDR;
    end else if (beat_fire) begin
      if (head_last)
        pos <= ip_hdr_pkg::POS_HDR;  // Also covers one-beat packets
      else if (pos == ip_hdr_pkg::POS_HDR)
        pos <= ip_hdr_pkg::POS_SECOND;
      else
        pos <= ip_hdr_pkg::POS_REST;
    end
  end

endmodule

//--- ip_hdr_pkg.sv
//********************************************************************
// Ethernet/IPv4 header beat layout, seen as fields or as halfwords,
// checksum word positions and in-packet beat position codes
//********************************************************************

package ip_hdr_pkg;

  // First beat, Ethernet header then the start of IPv4
  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
    logic [7:0]  ver_ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] ident;
    logic [15:0] frag;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] hdr_csum;   // Carried checksum
    logic [31:0] src_ip;
    logic [15:0] dst_ip_hi;  // Rest of dst IP opens beat 1
  } hdr_fields_t;

  // Same 256 bits as halfwords, index 0 in the top bits
  typedef union packed {
    hdr_fields_t       f;
    logic [0:15][15:0] hw;
  } hdr_beat_u;

  // Checksum arithmetic
  localparam int CSUM_W = 16;
  localparam int SUM_W  = 2 * CSUM_W;  // Unfolded sum, room for carries

  // Halfwords of the IP header inside beat 0
  localparam int CSUM_WORD_FIRST = 7;   // ver_ihl/tos
  localparam int CSUM_WORD_LAST  = 15;  // dst_ip_hi
  localparam int CSUM_WORD_SKIP  = 12;  // Carried hdr_csum, left out
  localparam int B1_CSUM_WORD    = 0;   // Beat 1, low half of dst IP

  // Beat position inside a packet
  localparam int POS_W = 2;
  localparam logic [POS_W-1:0] POS_HDR    = 2'd0;  // Beat 0 at head
  localparam logic [POS_W-1:0] POS_SECOND = 2'd1;  // Beat 1 at head
  localparam logic [POS_W-1:0] POS_REST   = 2'd2;  // Payload beats

endpackage

//--- out_rewrite.sv
//********************************************************************
// Destination byte rewrite on the header beat
// Checksum fold, invert and the registered per-packet report
//********************************************************************

`timescale 1ns/1ps

module out_rewrite (
  input  logic                           AXI_ACLK,
  input  logic                           AXI_RESETN,
  input  logic [stream_pkg::TUSER_W-1:0] head_tuser,
  input  logic                           hdr_beat,
  input  logic [stream_pkg::PORT_W-1:0]  dst_port,
  input  logic [ip_hdr_pkg::SUM_W-1:0]   csum_sum,
  input  logic [ip_hdr_pkg::CSUM_W-1:0]  rx_csum,
  input  logic                           sum_done,
  output logic [stream_pkg::TUSER_W-1:0] m_axis_tuser,
  output logic                           csum_valid,
  output logic [ip_hdr_pkg::CSUM_W-1:0]  hdr_csum,
  output logic                           csum_match
);

  localparam int CW = ip_hdr_pkg::CSUM_W;

  logic [CW:0]   fold1;      // First fold, may carry
  logic [CW-1:0] fold2;      // Cannot carry again
  logic [CW-1:0] csum_calc;

  // Only the header beat gets a new destination
  always_comb begin
    m_axis_tuser = head_tuser;
    if (hdr_beat && (dst_port != '0))
      m_axis_tuser[stream_pkg::DST_PORT_POS +: stream_pkg::PORT_W] = dst_port;
  end

  // End-around carry, twice is enough for this sum size
  assign fold1     = {1'b0, csum_sum[CW-1:0]} + {1'b0, csum_sum[ip_hdr_pkg::SUM_W-1:CW]};
  assign fold2     = fold1[CW-1:0] + {{(CW-1){1'b0}}, fold1[CW]};
  assign csum_calc = ~fold2;

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN)
      csum_valid <= 1'b0;
    else
      csum_valid <= sum_done;  // One pulse per packet
  end

  // Report payload, held until the next packet
  always_ff @(posedge AXI_ACLK) begin
    if (sum_done) begin
      hdr_csum   <= csum_calc;
      csum_match <= (csum_calc == rx_csum);
    end
  end

endmodule

//--- pkt_fifo.sv
//********************************************************************
// Small fall-through FIFO for tdata, tuser and tlast
// Oldest entry is presented at the head, pop is combinational
//********************************************************************

`timescale 1ns/1ps

module pkt_fifo (
  input  logic                           AXI_ACLK,
  input  logic                           AXI_RESETN,
  input  logic [stream_pkg::DATA_W-1:0]  wr_tdata,
  input  logic [stream_pkg::TUSER_W-1:0] wr_tuser,
  input  logic                           wr_tlast,
  input  logic                           wr_en,
  input  logic                           pop,
  output logic [stream_pkg::DATA_W-1:0]  head_tdata,
  output logic [stream_pkg::TUSER_W-1:0] head_tuser,
  output logic                           head_tlast,
  output logic                           head_valid,
  output logic                           nearly_full
);

  // Storage
  logic [stream_pkg::DATA_W-1:0]  data_mem [stream_pkg::FIFO_DEPTH];
  logic [stream_pkg::TUSER_W-1:0] user_mem [stream_pkg::FIFO_DEPTH];
  logic                           last_mem [stream_pkg::FIFO_DEPTH];

  logic [stream_pkg::FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [stream_pkg::FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [stream_pkg::FIFO_DEPTH_BITS:0]   count;  // 0..DEPTH

  always_ff @(posedge AXI_ACLK) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= wr_tdata;
      user_mem[wr_ptr] <= wr_tuser;
      last_mem[wr_ptr] <= wr_tlast;
    end
  end

  // Pointers wrap naturally at the depth
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // Head straight off the read pointer
  assign head_tdata = data_mem[rd_ptr];
  assign head_tuser = user_mem[rd_ptr];
  assign head_tlast = last_mem[rd_ptr];
  assign head_valid = (count != '0);

  // Leaves room for a beat already in flight
  assign nearly_full = (count >= stream_pkg::FIFO_NEAR_FULL);

endmodule

//--- route_exec.sv
//********************************************************************
// Destination port map from the source port
// Header checksum accumulation over beat 0 and the top of beat 1
//********************************************************************

`timescale 1ns/1ps

module route_exec (
  input  logic                           AXI_ACLK,
  input  logic                           AXI_RESETN,
  input  logic [stream_pkg::DATA_W-1:0]  head_tdata,
  input  logic [stream_pkg::PORT_W-1:0]  src_port,
  input  logic                           beat_fire,
  input  logic                           hdr_beat,
  input  logic                           second_fire,
  output logic [stream_pkg::PORT_W-1:0]  dst_port,
  output logic [ip_hdr_pkg::SUM_W-1:0]   csum_sum,
  output logic [ip_hdr_pkg::CSUM_W-1:0]  rx_csum,
  output logic                           sum_done
);

  localparam int PAD_W = ip_hdr_pkg::SUM_W - ip_hdr_pkg::CSUM_W;

  ip_hdr_pkg::hdr_beat_u           beat;
  logic [ip_hdr_pkg::SUM_W-1:0]    hdr_sum;   // Beat 0 part
  logic                            cpu_src;

  assign beat    = head_tdata;
  assign cpu_src = |(src_port & stream_pkg::CPU_PORT_MASK);  // Any odd bit

  // Later source bits win the port map
  always_comb begin
    dst_port = '0;  // Zero means leave tuser alone
    if (cpu_src) begin
      dst_port = stream_pkg::PORT_NF1;
    end else begin
      if (src_port[0]) dst_port = stream_pkg::PORT_NF1;
      if (src_port[2]) dst_port = stream_pkg::PORT_NF0;
      if (src_port[4]) dst_port = stream_pkg::PORT_NF3;
      if (src_port[6]) dst_port = stream_pkg::PORT_NF2;
    end
  end

  // Beat 0 IP header halfwords except the carried checksum
  always_comb begin
    hdr_sum = '0;
    for (int i = ip_hdr_pkg::CSUM_WORD_FIRST; i <= ip_hdr_pkg::CSUM_WORD_LAST; i++) begin
      if (i != ip_hdr_pkg::CSUM_WORD_SKIP)
        hdr_sum = hdr_sum + {{PAD_W{1'b0}}, beat.hw[i]};
    end
  end

  // Sum starts on the header beat and takes beat 1 on the second fire
  always_ff @(posedge AXI_ACLK) begin
    if (beat_fire && hdr_beat) begin
      csum_sum <= hdr_sum;
      rx_csum  <= beat.f.hdr_csum;
    end else if (second_fire) begin
      csum_sum <= csum_sum + {{PAD_W{1'b0}}, beat.hw[ip_hdr_pkg::B1_CSUM_WORD]};
    end
  end

  // Strobe rides along with the beat 1 update
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN)
      sum_done <= 1'b0;
    else
      sum_done <= second_fire;
  end

endmodule

//--- router_opl_chk.sv
//********************************************************************
// Protocol assertions for the lookup stage, bound to the top level
//********************************************************************

`timescale 1ns/1ps

module router_opl_chk (
  input logic                          AXI_ACLK,
  input logic                          AXI_RESETN,
  input logic [stream_pkg::DATA_W-1:0] m_axis_tdata,
  input logic                          m_axis_tvalid,
  input logic                          m_axis_tready,
  input logic                          s_axis_tready,
  input logic                          csum_valid
);

  // Stalled head must not change
  a_hold_data: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
    (m_axis_tvalid && !m_axis_tready) |=> $stable(m_axis_tdata))
    else $error("m_axis_tdata changed while stalled");

  // Report is a single-cycle strobe
  a_csum_pulse: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
    csum_valid |=> !csum_valid)
    else $error("csum_valid high for two cycles");

  // Ready right out of reset
  a_ready_reset: assert property (@(posedge AXI_ACLK)
    $rose(AXI_RESETN) |-> s_axis_tready)
    else $error("s_axis_tready low after reset");

endmodule

bind router_opl_top router_opl_chk u_chk (.*);

//--- router_opl_top.sv
//********************************************************************
// Output port lookup stage top level
// Input FIFO, beat decode, route/checksum execute, tuser rewrite
//********************************************************************

`timescale 1ns/1ps

module router_opl_top (
  input  logic                           AXI_ACLK,
  input  logic                           AXI_RESETN,

  // Slave stream from the RX queues
  input  logic [stream_pkg::DATA_W-1:0]  s_axis_tdata,
  input  logic [stream_pkg::TUSER_W-1:0] s_axis_tuser,
  input  logic                           s_axis_tvalid,
  output logic                           s_axis_tready,
  input  logic                           s_axis_tlast,

  // Master stream to the output queues
  output logic [stream_pkg::DATA_W-1:0]  m_axis_tdata,
  output logic [stream_pkg::TUSER_W-1:0] m_axis_tuser,
  output logic                           m_axis_tvalid,
  input  logic                           m_axis_tready,
  output logic                           m_axis_tlast,

  // Checksum report, strobe only
  output logic                           csum_valid,
  output logic [ip_hdr_pkg::CSUM_W-1:0]  hdr_csum,
  output logic                           csum_match
);

  logic                           wr_en;
  logic                           nearly_full;
  logic [stream_pkg::TUSER_W-1:0] head_tuser;  // Before rewrite
  logic                           pop;
  logic                           beat_fire;
  logic                           hdr_beat;
  logic                           second_fire;
  logic [stream_pkg::PORT_W-1:0]  src_port;
  logic [stream_pkg::PORT_W-1:0]  dst_port;
  logic [ip_hdr_pkg::SUM_W-1:0]   csum_sum;
  logic [ip_hdr_pkg::CSUM_W-1:0]  rx_csum;
  logic                           sum_done;

  assign s_axis_tready = ~nearly_full;
  assign wr_en         = s_axis_tvalid & s_axis_tready;

  // Head data and tlast leave unchanged
  pkt_fifo u_fifo (
    .AXI_ACLK    (AXI_ACLK),
    .AXI_RESETN  (AXI_RESETN),
    .wr_tdata    (s_axis_tdata),
    .wr_tuser    (s_axis_tuser),
    .wr_tlast    (s_axis_tlast),
    .wr_en       (wr_en),
    .pop         (pop),
    .head_tdata  (m_axis_tdata),
    .head_tuser  (head_tuser),
    .head_tlast  (m_axis_tlast),
    .head_valid  (m_axis_tvalid),
    .nearly_full (nearly_full)
  );

  hdr_decode u_decode (
    .AXI_ACLK    (AXI_ACLK),
    .AXI_RESETN  (AXI_RESETN),
    .head_valid  (m_axis_tvalid),
    .head_last   (m_axis_tlast),
    .head_tuser  (head_tuser),
    .out_ready   (m_axis_tready),
    .pop         (pop),
    .beat_fire   (beat_fire),
    .hdr_beat    (hdr_beat),
    .second_fire (second_fire),
    .src_port    (src_port)
  );

  route_exec u_exec (
    .AXI_ACLK    (AXI_ACLK),
    .AXI_RESETN  (AXI_RESETN),
    .head_tdata  (m_axis_tdata),
    .src_port    (src_port),
    .beat_fire   (beat_fire),
    .hdr_beat    (hdr_beat),
    .second_fire (second_fire),
    .dst_port    (dst_port),
    .csum_sum    (csum_sum),
    .rx_csum     (rx_csum),
    .sum_done    (sum_done)
  );

  out_rewrite u_result (
    .AXI_ACLK     (AXI_ACLK),
    .AXI_RESETN   (AXI_RESETN),
    .head_tuser   (head_tuser),
    .hdr_beat     (hdr_beat),
    .dst_port     (dst_port),
    .csum_sum     (csum_sum),
    .rx_csum      (rx_csum),
    .sum_done     (sum_done),
    .m_axis_tuser (m_axis_tuser),
    .csum_valid   (csum_valid),
    .hdr_csum     (hdr_csum),
    .csum_match   (csum_match)
  );

endmodule

//--- stream_pkg.sv
//********************************************************************
// Stream format constants: data and tuser widths, port byte fields
// in tuser, FIFO sizing and the one-hot port codes
//********************************************************************

package stream_pkg;

  // Bus widths
  localparam int DATA_W  = 256;
  localparam int TUSER_W = 128;

  // Port bytes in tuser
  localparam int SRC_PORT_POS = 16;  // One-hot source port
  localparam int DST_PORT_POS = 24;  // One-hot destination port
  localparam int PORT_W       = 8;

  // Input FIFO
  localparam int FIFO_DEPTH_BITS = 2;
  localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_BITS;

  // Ready drops at this fill level, leaves one slot of slack
  localparam logic [FIFO_DEPTH_BITS:0] FIFO_NEAR_FULL =
    (FIFO_DEPTH_BITS + 1)'(FIFO_DEPTH - 1);

  // Physical MAC ports sit on even bits
  localparam logic [PORT_W-1:0] PORT_NF0 = 8'b0000_0001;
  localparam logic [PORT_W-1:0] PORT_NF1 = 8'b0000_0100;
  localparam logic [PORT_W-1:0] PORT_NF2 = 8'b0001_0000;
  localparam logic [PORT_W-1:0] PORT_NF3 = 8'b0100_0000;

  // Odd bits are the CPU DMA queues
  localparam logic [PORT_W-1:0] CPU_PORT_MASK = 8'b1010_1010;

endpackage

//--- tb_router_opl.sv
//********************************************************************
// Directed testbench for the output port lookup stage
// Clock, reset, packet driver, output and report monitors, verdict
//********************************************************************

`timescale 1ns/1ps

module tb_router_opl;

  logic                           AXI_ACLK;
  logic                           AXI_RESETN;
  logic [stream_pkg::DATA_W-1:0]  s_axis_tdata;
  logic [stream_pkg::TUSER_W-1:0] s_axis_tuser;
  logic                           s_axis_tvalid;
  logic                           s_axis_tready;
  logic                           s_axis_tlast;
  logic [stream_pkg::DATA_W-1:0]  m_axis_tdata;
  logic [stream_pkg::TUSER_W-1:0] m_axis_tuser;
  logic                           m_axis_tvalid;
  logic                           m_axis_tready;
  logic                           m_axis_tlast;
  logic                           csum_valid;
  logic [15:0]                    hdr_csum;
  logic                           csum_match;

  // Expected output beats and reports in arrival order
  logic [stream_pkg::DATA_W-1:0]  exp_data [$];
  logic [stream_pkg::TUSER_W-1:0] exp_user [$];
  logic                           exp_last [$];
  logic [15:0]                    exp_csum [$];
  logic                           exp_match [$];

  string test_name = "init";
  int    errors    = 0;
  int    timeouts  = 0;
  bit    bp_mode   = 1'b0;  // Random sink stalls
  bit    saw_full  = 1'b0;

  router_opl_top UUT (.*);

  initial begin
    AXI_ACLK = 1'b0;
    forever #50 AXI_ACLK = ~AXI_ACLK;
  end

  // Sink ready is mostly low when stalling
  always @(posedge AXI_ACLK)
    m_axis_tready <= bp_mode ? (($urandom % 4) == 0) : 1'b1;

  // Highest source bit decides the route
  function automatic logic [7:0] route_for(input logic [7:0] src);
    if ((src & 8'haa) != 8'h00) return stream_pkg::PORT_NF1;  // From CPU
    if (src[6]) return stream_pkg::PORT_NF2;
    if (src[4]) return stream_pkg::PORT_NF3;
    if (src[2]) return stream_pkg::PORT_NF0;
    if (src[0]) return stream_pkg::PORT_NF1;
    return 8'h00;
  endfunction

  // One's-complement header sum folded and inverted
  function automatic logic [15:0] ref_csum(input logic [255:0] b0, input logic [255:0] b1);
    logic [31:0] sum;
    sum = {16'h0, b1[255:240]};  // Low half of dst IP
    for (int i = 7; i <= 15; i++)
      if (i != 12)
        sum = sum + {16'h0, b0[255-16*i -: 16]};
    while (sum[31:16] != 16'h0)
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    return ~sum[15:0];
  endfunction

  function automatic logic [255:0] rand256();
    logic [255:0] r;
    r = '0;
    for (int i = 0; i < 8; i++)
      r = {r[223:0], $urandom};
    return r;
  endfunction

  // Builds one packet and queues its expectations before driving it
  task automatic send_packet(input int nbeats, input logic [7:0] src, input bit corrupt);
    logic [255:0]  beats [];
    logic [127:0]  user;
    logic [127:0]  exp_u;
    logic [15:0]   good;
    logic [7:0]    dst;
    int            cycles;
    ip_hdr_pkg::hdr_beat_u hb;
    beats = new[nbeats];
    for (int i = 0; i < nbeats; i++)
      beats[i] = rand256();
    hb   = beats[0];
    good = ref_csum(beats[0], beats[1]);
    hb.f.hdr_csum = corrupt ? (good ^ 16'h0f0f) : good;  // Bad field on request
    beats[0] = hb;
    exp_csum.push_back(good);
    exp_match.push_back(!corrupt);
    dst = route_for(src);
    for (int i = 0; i < nbeats; i++) begin
      user = {$urandom, $urandom, $urandom, $urandom};
      if (i == 0)
        user[stream_pkg::SRC_PORT_POS +: 8] = src;
      exp_u = user;
      if (i == 0 && dst != 8'h00)
        exp_u[stream_pkg::DST_PORT_POS +: 8] = dst;  // Header beat rewrite
      exp_data.push_back(beats[i]);
      exp_last.push_back(i == nbeats - 1);
      exp_user.push_back(exp_u);
      s_axis_tdata  <= beats[i];
      s_axis_tuser  <= user;
      s_axis_tlast  <= (i == nbeats - 1);
      s_axis_tvalid <= 1'b1;
      cycles = 0;
      do begin
        @(posedge AXI_ACLK);
        cycles++;
      end while (!s_axis_tready && cycles < 200);
      if (!s_axis_tready) begin
        $display("%s: input beat was never accepted", test_name);
        timeouts++;
      end
    end
  endtask

  // Wait until all expected beats and reports came out
  task automatic drain();
    int cycles;
    s_axis_tvalid <= 1'b0;
    cycles = 0;
    while ((exp_data.size() != 0 || exp_csum.size() != 0) && cycles < 2000) begin
      @(posedge AXI_ACLK);
      cycles++;
    end
    if (exp_data.size() != 0 || exp_csum.size() != 0) begin
      $display("%s: %0d beats and %0d checksum reports never arrived",
               test_name, exp_data.size(), exp_csum.size());
      timeouts++;
      exp_data.delete();
      exp_user.delete();
      exp_last.delete();
      exp_csum.delete();
      exp_match.delete();
    end
  endtask

  // Output beat monitor
  always @(posedge AXI_ACLK) begin
    if (bp_mode && !s_axis_tready)
      saw_full = 1'b1;
    if (AXI_RESETN && m_axis_tvalid && m_axis_tready) begin
      if (exp_data.size() == 0) begin
        $display("%s: output beat with nothing expected", test_name);
        errors++;
      end else begin
        if (m_axis_tdata != exp_data[0]) begin
          $display("FAILED %s tdata expected %h actual %h", test_name, exp_data[0], m_axis_tdata);
          errors++;
        end
        if (m_axis_tuser != exp_user[0]) begin
          $display("FAILED %s tuser expected %h actual %h", test_name, exp_user[0], m_axis_tuser);
          errors++;
        end
        if (m_axis_tlast != exp_last[0]) begin
          $display("FAILED %s tlast expected %b actual %b", test_name, exp_last[0], m_axis_tlast);
          errors++;
        end
        void'(exp_data.pop_front());
        void'(exp_user.pop_front());
        void'(exp_last.pop_front());
      end
    end
  end

  // Checksum report monitor
  always @(posedge AXI_ACLK) begin
    if (AXI_RESETN && csum_valid) begin
      if (exp_csum.size() == 0) begin
        $display("%s: checksum report with no packet pending", test_name);
        errors++;
      end else begin
        if (hdr_csum != exp_csum[0]) begin
          $display("FAILED %s hdr_csum expected %h actual %h", test_name, exp_csum[0], hdr_csum);
          errors++;
        end
        if (csum_match != exp_match[0]) begin
          $display("FAILED %s csum_match expected %b actual %b",
                   test_name, exp_match[0], csum_match);
          errors++;
        end
        void'(exp_csum.pop_front());
        void'(exp_match.pop_front());
      end
    end
  end

  task automatic check_reset_state();
    test_name = "reset";
    if (s_axis_tready !== 1'b1) begin
      $display("FAILED %s s_axis_tready expected 1 actual %b", test_name, s_axis_tready);
      errors++;
    end
    if (m_axis_tvalid !== 1'b0) begin
      $display("FAILED %s m_axis_tvalid expected 0 actual %b", test_name, m_axis_tvalid);
      errors++;
    end
    if (csum_valid !== 1'b0) begin
      $display("FAILED %s csum_valid expected 0 actual %b", test_name, csum_valid);
      errors++;
    end
  endtask

  task automatic route_phys_ports();
    test_name = "phys_routing";
    send_packet(3, 8'h01, 1'b0);
    send_packet(3, 8'h04, 1'b0);
    send_packet(2, 8'h10, 1'b0);
    send_packet(4, 8'h40, 1'b0);
    drain();
  endtask

  task automatic route_cpu_ports();
    test_name = "cpu_routing";
    send_packet(3, 8'h02, 1'b0);
    send_packet(2, 8'h20, 1'b0);
    send_packet(3, 8'h00, 1'b0);  // No source bit leaves tuser untouched
    drain();
  endtask

  task automatic verify_checksums();
    test_name = "checksum";
    for (int i = 0; i < 8; i++)
      send_packet(2 + ($urandom % 4), 8'h01 << (2 * (i % 4)), i[0]);
    drain();
  endtask

  task automatic stress_backpressure();
    test_name = "backpressure";
    saw_full = 1'b0;
    bp_mode  = 1'b1;
    for (int i = 0; i < 10; i++)
      send_packet(2 + ($urandom % 3), 8'h04, (i % 3) == 0);
    drain();
    bp_mode = 1'b0;
    if (!saw_full) begin
      $display("%s: s_axis_tready never dropped under back-pressure", test_name);
      errors++;
    end
  endtask

  initial begin
    void'($urandom(63572));
    AXI_RESETN    <= 1'b0;
    s_axis_tdata  <= '0;
    s_axis_tuser  <= '0;
    s_axis_tvalid <= 1'b0;
    s_axis_tlast  <= 1'b0;
    m_axis_tready <= 1'b1;
    repeat (4) @(posedge AXI_ACLK);
    AXI_RESETN <= 1'b1;
    @(posedge AXI_ACLK);
    check_reset_state();
    route_phys_ports();
    route_cpu_ports();
    verify_checksums();
    stress_backpressure();
    repeat (4) @(posedge AXI_ACLK);
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
